// ==== logic/fpu_macros.svh ====
// shared sizes for the FPU execute block
// include wherever the queue depth, tag width or canonical NaN is needed
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// operation queue entries, also the issuer's starting credit count
`define FPU_QUEUE_DEPTH 2

// destination register tag width (x0..x31 / f0..f31)
`define FPU_TAG_W 5

// canonical quiet NaN returned by the multiplier and min/max
`define FPU_CANON_NAN 32'h7fc00000

`endif

// ==== logic/fpu_pkg.sv ====
// types shared by the FPU execute block and its testbench
// reference with fpu_pkg::name, no import
`default_nettype none

package fpu_pkg;

  ////////////////////
  // opcodes
  ////////////////////
  typedef enum logic [3:0] {
    op_fmul   = 4'd0,   // multi-cycle unit
    op_fsgnj  = 4'd1,   // sign from b
    op_fsgnjn = 4'd2,   // inverted sign from b
    op_fsgnjx = 4'd3,   // sign a xor sign b
    op_fmin   = 4'd4,
    op_fmax   = 4'd5,
    op_feq    = 4'd6,   // compares return 0/1
    op_flt    = 4'd7,
    op_fle    = 4'd8,
    op_fclass = 4'd9,   // 10-bit one-hot class
    op_fmv    = 4'd10   // raw bit move
  } fpu_op_e;

  ////////////////////
  // multiplier fsm
  ////////////////////
  typedef enum logic [1:0] {
    mul_idle = 2'd0,  // waiting for start
    mul_iter = 2'd1,  // shift-add, one multiplier bit per cycle
    mul_norm = 2'd2,  // normalize, truncate, range check
    mul_done = 2'd3   // result valid for one cycle
  } mul_state_e;

endpackage

`default_nettype wire

// ==== logic/fp_op_queue.sv ====
// circular FIFO holding issued FPU operations until the dispatcher retires them
// every pop hands one credit back to the issuer on the following cycle
// never overflows as long as the issuer respects its credits
`timescale 1ns/1ps
`default_nettype none
`include "fpu_macros.svh"

module fp_op_queue (
  input  wire logic                     g_clk,
  input  wire logic                     g_rst,
  input  wire logic                     push,
  input  wire fpu_pkg::fpu_op_e         push_code,
  input  wire logic [31:0]              push_a,
  input  wire logic [31:0]              push_b,
  input  wire logic [`FPU_TAG_W-1:0]    push_tag,
  input  wire logic                     pop,
  output logic                          head_valid,
  output fpu_pkg::fpu_op_e              head_code,
  output logic [31:0]                   head_a,
  output logic [31:0]                   head_b,
  output logic [`FPU_TAG_W-1:0]         head_tag,
  output logic                          credit_return
);

  localparam int DEPTH = `FPU_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

  fpu_pkg::fpu_op_e         code_mem [DEPTH];  // payload, no reset
  logic [31:0]              a_mem    [DEPTH];
  logic [31:0]              b_mem    [DEPTH];
  logic [`FPU_TAG_W-1:0]    tag_mem  [DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         count;
  logic                     do_pop;

  assign head_valid = (count != '0);
  assign do_pop     = pop & head_valid;  // ignore pop on empty

  // head is read straight out of storage
  assign head_code = code_mem[rd_ptr];
  assign head_a    = a_mem[rd_ptr];
  assign head_b    = b_mem[rd_ptr];
  assign head_tag  = tag_mem[rd_ptr];

  always_ff @(posedge g_clk) begin
    if (push) begin
      code_mem[wr_ptr] <= push_code;
      a_mem[wr_ptr]    <= push_a;
      b_mem[wr_ptr]    <= push_b;
      tag_mem[wr_ptr]  <= push_tag;
    end
  end

  always_ff @(posedge g_clk) begin
    if (g_rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= do_pop;  // one credit per retired op, a cycle late
      if (push) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;  // wrap, any depth
      if (do_pop) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/fp_misc_unit.sv ====
// single-cycle FP ops: sign injection, min/max, compares, classify and move
// purely combinational, fed from the queue head
// works on the raw encodings, subnormals are ordered and classified as is
`timescale 1ns/1ps
`default_nettype none
`include "fpu_macros.svh"

module fp_misc_unit (
  input  wire fpu_pkg::fpu_op_e code,
  input  wire logic [31:0]      a,
  input  wire logic [31:0]      b,
  output logic [31:0]           res
);

  logic a_nan, b_nan;
  logic both_zero;     // +0 and -0 compare equal
  logic a_below_b;     // total order, -0 below +0
  logic eq, lt;
  logic [9:0] cls;

  // sign-magnitude order for non-NaN values
  function automatic logic order_lt(input logic [31:0] x, input logic [31:0] y);
    if (x[31] != y[31]) return x[31];         // negative side is smaller
    else if (!x[31]) return x[30:0] < y[30:0];
    else return x[30:0] > y[30:0];            // both negative, bigger mag is smaller
  endfunction

  ////////////////////
  // operand decode
  ////////////////////
  assign a_nan     = (a[30:23] == 8'hff) && (a[22:0] != '0);
  assign b_nan     = (b[30:23] == 8'hff) && (b[22:0] != '0);
  assign both_zero = (a[30:0] == '0) && (b[30:0] == '0);
  assign a_below_b = order_lt(a, b);
  assign eq        = !a_nan && !b_nan && ((a == b) || both_zero);
  assign lt        = !a_nan && !b_nan && a_below_b && !both_zero;

  // riscv fclass, one bit per class
  always_comb begin
    cls = '0;
    if (a[30:23] == 8'hff) begin
      if (a[22:0] == '0) cls[a[31] ? 0 : 7] = 1'b1;  // inf
      else if (a[22])    cls[9] = 1'b1;               // quiet nan
      else               cls[8] = 1'b1;               // signaling nan
    end else if (a[30:23] == 8'h00) begin
      if (a[22:0] == '0) cls[a[31] ? 3 : 4] = 1'b1;   // zero
      else               cls[a[31] ? 2 : 5] = 1'b1;   // subnormal
    end else begin
      cls[a[31] ? 1 : 6] = 1'b1;                      // normal
    end
  end

  ////////////////////
  // result select
  ////////////////////
  always_comb begin
    case (code)
      fpu_pkg::op_fsgnj:  res = {b[31], a[30:0]};
      fpu_pkg::op_fsgnjn: res = {~b[31], a[30:0]};
      fpu_pkg::op_fsgnjx: res = {a[31] ^ b[31], a[30:0]};
      fpu_pkg::op_fmin: begin
        if (a_nan && b_nan) res = `FPU_CANON_NAN;
        else if (a_nan)     res = b;   // the number wins over a nan
        else if (b_nan)     res = a;
        else                res = a_below_b ? a : b;
      end
      fpu_pkg::op_fmax: begin
        if (a_nan && b_nan) res = `FPU_CANON_NAN;
        else if (a_nan)     res = b;
        else if (b_nan)     res = a;
        else                res = a_below_b ? b : a;
      end
      fpu_pkg::op_feq:    res = {31'b0, eq};
      fpu_pkg::op_flt:    res = {31'b0, lt};
      fpu_pkg::op_fle:    res = {31'b0, lt | eq};
      fpu_pkg::op_fclass: res = {22'b0, cls};
      fpu_pkg::op_fmv:    res = a;
      default:            res = '0;  // fmul, not this unit
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/fp_mul_unit.sv ====
// iterative single-precision multiplier, one significand bit per cycle
// start is sampled in idle; done pulses 1 cycle later for specials, 25 otherwise
// truncates toward zero, flushes subnormals, saturates overflow to max finite
`timescale 1ns/1ps
`default_nettype none
`include "fpu_macros.svh"

module fp_mul_unit (
  input  wire logic        g_clk,
  input  wire logic        g_rst,
  input  wire logic        start,
  input  wire logic [31:0] a,
  input  wire logic [31:0] b,
  output logic             done,
  output logic [31:0]      res
);

  fpu_pkg::mul_state_e state;
  logic [4:0]          iter_q;    // 23 add steps after the load step
  logic [47:0]         prod_q;    // partial product
  logic [47:0]         mcand_q;   // multiplicand, shifted left each step
  logic [23:0]         mplier_q;  // multiplier, shifted right each step
  logic                sign_q;
  logic signed [9:0]   exp_q;     // biased exponent sum, may go out of range
  logic [31:0]         res_q;
  logic a_zero, b_zero, a_inf, b_inf, a_nan, b_nan, special;
  logic [31:0]         special_res;
  logic signed [9:0]   exp_n;
  logic [22:0]         frac_n;

  ////////////////////
  // special operands
  ////////////////////
  assign a_zero  = (a[30:23] == 8'h00);                       // zero or subnormal
  assign b_zero  = (b[30:23] == 8'h00);
  assign a_inf   = (a[30:23] == 8'hff) && (a[22:0] == '0);
  assign b_inf   = (b[30:23] == 8'hff) && (b[22:0] == '0);
  assign a_nan   = (a[30:23] == 8'hff) && (a[22:0] != '0);
  assign b_nan   = (b[30:23] == 8'hff) && (b[22:0] != '0);
  assign special = a_zero | b_zero | a_inf | b_inf | a_nan | b_nan;

  always_comb begin
    if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero))
      special_res = `FPU_CANON_NAN;
    else if (a_inf || b_inf)
      special_res = {a[31] ^ b[31], 8'hff, 23'b0};  // signed inf
    else
      special_res = {a[31] ^ b[31], 31'b0};         // signed zero
  end

  // product of two 1.x values lies in [1,4), at most one shift
  assign exp_n  = prod_q[47] ? exp_q + 10'sd1 : exp_q;
  assign frac_n = prod_q[47] ? prod_q[46:24] : prod_q[45:23];

  ////////////////////
  // control
  ////////////////////
  always_ff @(posedge g_clk) begin
    if (g_rst) begin
      state  <= fpu_pkg::mul_idle;
      iter_q <= '0;
    end else begin
      case (state)
        fpu_pkg::mul_idle: begin
          iter_q <= '0;
          if (start) state <= special ? fpu_pkg::mul_done : fpu_pkg::mul_iter;
        end
        fpu_pkg::mul_iter: begin
          iter_q <= iter_q + 5'd1;
          if (iter_q == 5'd22) state <= fpu_pkg::mul_norm;  // last multiplier bit
        end
        fpu_pkg::mul_norm: state <= fpu_pkg::mul_done;
        default:           state <= fpu_pkg::mul_idle;  // done lasts one cycle
      endcase
    end
  end

  ////////////////////
  // datapath
  ////////////////////
  always_ff @(posedge g_clk) begin
    case (state)
      fpu_pkg::mul_idle: begin
        if (start) begin
          res_q    <= special_res;  // only kept when special
          sign_q   <= a[31] ^ b[31];
          exp_q    <= $signed({2'b0, a[30:23]}) + $signed({2'b0, b[30:23]}) - 10'sd127;
          prod_q   <= b[0] ? {24'b0, 1'b1, a[22:0]} : 48'b0;  // bit 0 folded into load
          mcand_q  <= {23'b0, 1'b1, a[22:0], 1'b0};
          mplier_q <= {2'b01, b[22:1]};
        end
      end
      fpu_pkg::mul_iter: begin
        if (mplier_q[0]) prod_q <= prod_q + mcand_q;
        mcand_q  <= mcand_q << 1;
        mplier_q <= mplier_q >> 1;
      end
      fpu_pkg::mul_norm: begin
        if (exp_n >= 10'sd255)    res_q <= {sign_q, 31'h7f7fffff};  // saturate
        else if (exp_n <= 10'sd0) res_q <= {sign_q, 31'b0};         // flush
        else                      res_q <= {sign_q, exp_n[7:0], frac_n};
      end
      default: res_q <= res_q;
    endcase
  end

  assign done = (state == fpu_pkg::mul_done);
  assign res  = res_q;

endmodule

`default_nettype wire

// ==== logic/fpu_dispatch.sv ====
// picks the unit for the queue head, waits on the multiplier, retires in order
// result_valid and pop are one registered pulse; head is stale while pop is high
`timescale 1ns/1ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_dispatch (
  input  wire logic                   g_clk,
  input  wire logic                   g_rst,
  input  wire logic                   head_valid,
  input  wire fpu_pkg::fpu_op_e       head_code,
  input  wire logic [`FPU_TAG_W-1:0]  head_tag,
  input  wire logic [31:0]            misc_res,
  input  wire logic                   mul_done,
  input  wire logic [31:0]            mul_res,
  output logic                        pop,
  output logic                        mul_start,
  output logic                        result_valid,
  output logic [31:0]                 result,
  output logic [`FPU_TAG_W-1:0]       result_tag
);

  logic                  busy;        // multiplier owns the head
  logic                  retire_q;    // drives both result_valid and pop
  logic                  head_new;    // head not yet started
  logic                  is_mul;
  logic                  retire_misc;
  logic                  retire_mul;
  logic [31:0]           result_q;
  logic [`FPU_TAG_W-1:0] tag_q;

  ////////////////////
  // decode
  ////////////////////
  assign head_new    = head_valid & ~busy & ~retire_q;  // popping op still shows
  assign is_mul      = (head_code == fpu_pkg::op_fmul);
  assign mul_start   = head_new & is_mul;               // first head cycle
  assign retire_misc = head_new & ~is_mul;              // misc answers at once
  assign retire_mul  = busy & mul_done;

  always_ff @(posedge g_clk) begin
    if (g_rst) begin
      busy     <= 1'b0;
      retire_q <= 1'b0;
    end else begin
      retire_q <= retire_misc | retire_mul;
      if (mul_start)     busy <= 1'b1;
      else if (mul_done) busy <= 1'b0;
    end
  end

  // result and tag held until the next retire
  always_ff @(posedge g_clk) begin
    if (retire_misc || retire_mul) begin
      result_q <= retire_mul ? mul_res : misc_res;
      tag_q    <= head_tag;  // head stays put until pop
    end
  end

  assign result_valid = retire_q;
  assign pop          = retire_q;
  assign result       = result_q;
  assign result_tag   = tag_q;

endmodule

`default_nettype wire

// ==== logic/fpu_top.sv ====
// FPU execute block: credit-managed op queue, dispatcher, misc and multiply units
// issuer starts with FPU_QUEUE_DEPTH credits and gets one back per credit_return
`timescale 1ns/1ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_top (
  input  wire logic                   g_clk,
  input  wire logic                   g_rst,
  input  wire logic                   op_valid,
  input  wire fpu_pkg::fpu_op_e       op_code,
  input  wire logic [31:0]            op_a,
  input  wire logic [31:0]            op_b,
  input  wire logic [`FPU_TAG_W-1:0]  op_tag,
  output logic                        credit_return,
  output logic                        result_valid,
  output logic [31:0]                 result,
  output logic [`FPU_TAG_W-1:0]       result_tag
);

  logic                  head_valid;
  fpu_pkg::fpu_op_e      head_code;
  logic [31:0]           head_a, head_b;
  logic [`FPU_TAG_W-1:0] head_tag;
  logic                  pop;
  logic                  mul_start, mul_done;
  logic [31:0]           mul_res, misc_res;

  fp_op_queue i_queue (
    .g_clk, .g_rst,
    .push      (op_valid),
    .push_code (op_code),
    .push_a    (op_a),
    .push_b    (op_b),
    .push_tag  (op_tag),
    .pop, .head_valid, .head_code, .head_a, .head_b, .head_tag, .credit_return
  );

  fpu_dispatch i_dispatch (
    .g_clk, .g_rst, .head_valid, .head_code, .head_tag, .misc_res,
    .mul_done, .mul_res, .pop, .mul_start, .result_valid, .result, .result_tag
  );

  fp_misc_unit i_misc (.code(head_code), .a(head_a), .b(head_b), .res(misc_res));

  fp_mul_unit i_mul (
    .g_clk, .g_rst,
    .start (mul_start),
    .a     (head_a),
    .b     (head_b),
    .done  (mul_done),
    .res   (mul_res)
  );

endmodule

`default_nettype wire

// ==== sim/fpu_properties.sv ====
// concurrent checks on the FPU top level handshake, bound into fpu_top
`timescale 1ns/1ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_properties (
  input wire logic                  g_clk,
  input wire logic                  g_rst,
  input wire logic                  op_valid,
  input wire logic                  credit_return,
  input wire logic                  result_valid,
  input wire logic [31:0]           result,
  input wire logic [`FPU_TAG_W-1:0] result_tag,
  input wire fpu_pkg::mul_state_e   mul_state
);

  logic [3:0] outstanding;  // issued and not yet credited

  always_ff @(posedge g_clk) begin
    if (g_rst) outstanding <= '0;
    else outstanding <= outstanding + 4'(op_valid) - 4'(credit_return);
  end

  a_credit_pulse: assert property (@(posedge g_clk) disable iff (g_rst)
    credit_return |=> !credit_return) else $error("credit_return held two cycles");
  a_result_pulse: assert property (@(posedge g_clk) disable iff (g_rst)
    result_valid |=> !result_valid) else $error("result_valid held two cycles");
  a_in_flight: assert property (@(posedge g_clk) disable iff (g_rst)
    outstanding <= `FPU_QUEUE_DEPTH) else $error("more ops in flight than queue entries");
  a_ctrl_known: assert property (@(posedge g_clk) disable iff (g_rst)
    !$isunknown({op_valid, credit_return, result_valid, mul_state}))
    else $error("control signal is X");
  a_data_known: assert property (@(posedge g_clk) disable iff (g_rst)
    result_valid |-> !$isunknown({result, result_tag})) else $error("result is X");

endmodule

bind fpu_top fpu_properties i_props (
  .g_clk(g_clk), .g_rst(g_rst), .op_valid(op_valid), .credit_return(credit_return),
  .result_valid(result_valid), .result(result), .result_tag(result_tag),
  .mul_state(i_mul.state)
);

`default_nettype wire

// ==== sim/fpu_tb.sv ====
// testbench for the FPU execute block
// credit-respecting issuer on the falling edge, LFSR stimulus, reference model,
// and an in-order checker that pops the expected queue on every result_valid
`timescale 1ns/1ps
`default_nettype none
`include "fpu_macros.svh"

module fpu_tb;

  localparam int N_DIRECTED = 18;
  localparam int N_RANDOM   = 80;
  localparam int TIMEOUT    = 30 * (N_DIRECTED + N_RANDOM) + 100;  // slow fmul per op + margin

  logic                  g_clk = 1'b0;
  logic                  g_rst;
  logic                  op_valid;
  fpu_pkg::fpu_op_e      op_code;
  logic [31:0]           op_a;
  logic [31:0]           op_b;
  logic [`FPU_TAG_W-1:0] op_tag;
  logic                  credit_return;
  logic                  result_valid;
  logic [31:0]           result;
  logic [`FPU_TAG_W-1:0] result_tag;

  logic [31:0]           lfsr_state = 32'h2cd6d599;
  int                    credits;      // issuer side
  int                    cycles = 0;
  logic [`FPU_TAG_W-1:0] next_tag = '0;
  logic [31:0]           exp_vals [$];  // expected results in issue order
  logic [`FPU_TAG_W-1:0] exp_tags [$];

  fpu_top i_fpu_top (
    .g_clk, .g_rst, .op_valid, .op_code, .op_a, .op_b, .op_tag,
    .credit_return, .result_valid, .result, .result_tag
  );

  always #50 g_clk = ~g_clk;  // 100 ns period

  ////////////////////
  // stimulus helpers
  ////////////////////
  // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] bits;
    logic        fb;
    int          i;
    bits = '0;
    for (i = 0; i < nbits; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [31:0] special_operand(input logic [2:0] sel);
    case (sel)
      3'd0:    return 32'h0000_0000;  // +0
      3'd1:    return 32'h8000_0000;  // -0
      3'd2:    return 32'h7f80_0000;  // +inf
      3'd3:    return 32'hff80_0000;  // -inf
      3'd4:    return 32'h7fc0_0000;  // quiet nan
      3'd5:    return 32'hff80_0001;  // signaling nan
      3'd6:    return 32'h0001_2345;  // subnormal
      default: return 32'h8040_0000;  // negative subnormal
    endcase
  endfunction

  function automatic logic [31:0] random_operand();
    logic [2:0] pick;
    logic       sign;
    logic [7:0] expo;
    pick = 3'(lfsr_take(3));
    if (pick < 3'd2) return special_operand(3'(lfsr_take(3)));  // about one in four
    sign = 1'(lfsr_take(1));
    expo = 8'(lfsr_take(8));
    if (expo == 8'h00 || expo == 8'hff) expo = 8'h7f;  // keep it normal
    return {sign, expo, 23'(lfsr_take(23))};
  endfunction

  function automatic fpu_pkg::fpu_op_e random_opcode();
    logic [3:0] n;
    if (lfsr_take(1) != 0) return fpu_pkg::op_fmul;  // half multiplies
    n = 4'(lfsr_take(4) % 10) + 4'd1;
    return fpu_pkg::fpu_op_e'(n);
  endfunction

  ////////////////////
  // reference model
  ////////////////////
  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
  endfunction

  // unsigned key in numeric order with -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h8000_0000);
  endfunction

  function automatic logic [31:0] class_mask(input logic [31:0] x);
    int idx;
    if (x[30:23] == 8'hff) idx = (x[22:0] == 0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
    else if (x[30:23] == 8'h00) idx = (x[22:0] == 0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
    else idx = x[31] ? 1 : 6;
    return 32'd1 << idx;
  endfunction

  function automatic logic [31:0] expected_mul(input logic [31:0] a, input logic [31:0] b);
    logic        sign;
    logic        a_zero, b_zero, a_inf, b_inf;
    logic [47:0] prod;
    logic [22:0] frac;
    int          expo;
    sign   = a[31] ^ b[31];
    a_zero = (a[30:23] == 8'h00);  // subnormal flushes to zero
    b_zero = (b[30:23] == 8'h00);
    a_inf  = (a[30:0] == 31'h7f80_0000);
    b_inf  = (b[30:0] == 31'h7f80_0000);
    if (is_nan(a) || is_nan(b) || (a_inf && b_zero) || (b_inf && a_zero)) return `FPU_CANON_NAN;
    if (a_inf || b_inf) return {sign, 8'hff, 23'h0};
    if (a_zero || b_zero) return {sign, 31'h0};
    prod = {24'h0, 1'b1, a[22:0]} * {24'h0, 1'b1, b[22:0]};
    expo = int'(a[30:23]) + int'(b[30:23]) - 127;
    if (prod[47]) begin
      expo++;
      frac = prod[46:24];  // truncate
    end else begin
      frac = prod[45:23];
    end
    if (expo >= 255) return {sign, 31'h7f7f_ffff};  // saturate to max finite
    if (expo <= 0) return {sign, 31'h0};
    return {sign, 8'(expo), frac};
  endfunction

  function automatic logic [31:0] expected_result(input fpu_pkg::fpu_op_e code,
                                                  input logic [31:0] a, input logic [31:0] b);
    logic any_nan, zeros, less, equal;
    any_nan = is_nan(a) || is_nan(b);
    zeros   = (a[30:0] == 31'h0) && (b[30:0] == 31'h0);
    less    = order_key(a) < order_key(b);
    equal   = !any_nan && ((a == b) || zeros);
    case (code)
      fpu_pkg::op_fmul:   return expected_mul(a, b);
      fpu_pkg::op_fsgnj:  return {b[31], a[30:0]};
      fpu_pkg::op_fsgnjn: return {~b[31], a[30:0]};
      fpu_pkg::op_fsgnjx: return {a[31] ^ b[31], a[30:0]};
      fpu_pkg::op_fmin, fpu_pkg::op_fmax: begin
        if (is_nan(a) && is_nan(b)) return `FPU_CANON_NAN;
        if (is_nan(a)) return b;
        if (is_nan(b)) return a;
        return ((code == fpu_pkg::op_fmin) == less) ? a : b;
      end
      fpu_pkg::op_feq:    return {31'h0, equal};
      fpu_pkg::op_flt:    return {31'h0, !any_nan && less && !zeros};
      fpu_pkg::op_fle:    return {31'h0, equal || (!any_nan && less)};
      fpu_pkg::op_fclass: return class_mask(a);
      default:            return a;  // fmv
    endcase
  endfunction

  ////////////////////
  // checking
  ////////////////////
  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_result(input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("FAIL at %0t ns: result %h, expected %h", $time, got, want);
      stop_with_failure();
    end
  endtask

  task automatic check_tag(input logic [`FPU_TAG_W-1:0] got, input logic [`FPU_TAG_W-1:0] want);
    if (got !== want) begin
      $display("FAIL at %0t ns: result tag %0d, expected %0d", $time, got, want);
      stop_with_failure();
    end
  endtask

  // sampled mid-cycle with one pop per result_valid pulse
  always @(negedge g_clk) begin
    if (!g_rst && result_valid) begin
      if (exp_vals.size() == 0) begin
        $display("a result came back at %0t ns with no operation outstanding", $time);
        stop_with_failure();
      end else begin
        check_result(result, exp_vals.pop_front());
        check_tag(result_tag, exp_tags.pop_front());
      end
    end
  end

  always @(posedge g_clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("run timed out after %0d cycles, %0d results never came back",
               cycles, exp_vals.size());
      stop_with_failure();
    end
  end

  ////////////////////
  // issuer
  ////////////////////
  task automatic next_cycle();
    @(negedge g_clk);
    op_valid = 1'b0;  // valid lasts one cycle
    if (credit_return) credits++;
    if (credits > `FPU_QUEUE_DEPTH) begin
      $display("more credits came back than operations were issued, at %0t ns", $time);
      stop_with_failure();
    end
  endtask

  task automatic issue_op(input fpu_pkg::fpu_op_e code, input logic [31:0] a,
                          input logic [31:0] b);
    next_cycle();
    while (credits == 0) next_cycle();  // wait for a credit
    op_valid = 1'b1;
    op_code  = code;
    op_a     = a;
    op_b     = b;
    op_tag   = next_tag;
    credits--;
    exp_vals.push_back(expected_result(code, a, b));
    exp_tags.push_back(next_tag);
    next_tag++;
  endtask

  initial begin
    int i;
    g_rst    = 1'b1;
    op_valid = 1'b0;
    op_code  = fpu_pkg::op_fmv;
    op_a     = '0;
    op_b     = '0;
    op_tag   = '0;
    credits  = `FPU_QUEUE_DEPTH;
    repeat (2) @(negedge g_clk);
    g_rst = 1'b0;
    // fmul range and specials
    issue_op(fpu_pkg::op_fmul, 32'h7f00_0000, 32'h4000_0000);  // overflow
    issue_op(fpu_pkg::op_fmul, 32'hff00_0000, 32'h4040_0000);  // negative overflow
    issue_op(fpu_pkg::op_fmul, 32'h0080_0000, 32'h0080_0000);  // underflow
    issue_op(fpu_pkg::op_fmul, 32'h8080_0000, 32'h3f00_0000);  // underflow to -0
    issue_op(fpu_pkg::op_fmul, 32'h7f80_0000, 32'h0000_0000);  // inf * 0
    issue_op(fpu_pkg::op_fmul, 32'hff80_0000, 32'h4000_0000);
    issue_op(fpu_pkg::op_fmul, 32'h0001_2345, 32'h4040_0000);  // subnormal in
    issue_op(fpu_pkg::op_fmul, 32'h7fa0_0000, 32'h3f80_0000);
    // fast op queued behind a slow fmul
    issue_op(fpu_pkg::op_fmul, 32'h3fc0_0000, 32'h4010_0000);
    issue_op(fpu_pkg::op_fsgnjx, 32'hc000_0000, 32'h8000_0001);
    // zero ordering and nan handling
    issue_op(fpu_pkg::op_fmin, 32'h0000_0000, 32'h8000_0000);
    issue_op(fpu_pkg::op_fmax, 32'h8000_0000, 32'h0000_0000);
    issue_op(fpu_pkg::op_fmin, 32'h7fc0_0000, 32'h3f80_0000);
    issue_op(fpu_pkg::op_fmax, 32'h7f80_0001, 32'hffc0_0000);
    issue_op(fpu_pkg::op_feq, 32'h0000_0000, 32'h8000_0000);
    issue_op(fpu_pkg::op_flt, 32'h7fc0_0000, 32'h3f80_0000);
    issue_op(fpu_pkg::op_fclass, 32'hff80_0000, 32'h0000_0000);
    issue_op(fpu_pkg::op_fle, 32'h8000_0000, 32'h0000_0000);
    for (i = 0; i < N_RANDOM; i++) begin
      issue_op(random_opcode(), random_operand(), random_operand());
    end
    // every result in first
    while (exp_vals.size() != 0) next_cycle();
    // idle cycles let the last credits come home
    repeat (5) next_cycle();
    if (credits == `FPU_QUEUE_DEPTH) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("issuer ended with %0d credits instead of %0d", credits, `FPU_QUEUE_DEPTH);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/fpu_pkg.sv
logic/fp_op_queue.sv
logic/fp_misc_unit.sv
logic/fp_mul_unit.sv
logic/fpu_dispatch.sv
logic/fpu_top.sv
sim/fpu_properties.sv
sim/fpu_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := fpu_tb
FILELIST := files.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST)) logic/fpu_macros.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -F -q '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
